//--- Makefile
LOG = sim.log

sim:
	verilator --binary --timing -f sim.f --top-module tb_dbg_ppb_sel -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- bench/dbg_ppb_model.svh
`ifndef DBG_PPB_MODEL_SVH
`define DBG_PPB_MODEL_SVH

// ------------------------------
// Address tables

// Control registers in select bit order
// DFSR is bit 18 and DWT FUNC1 bit 0
// Bus split is dbg 18:15, cid 14:13, bpu 12:8, dwt 7:0
localparam logic [31:0] CTRL_ADDR [0:18] = '{
   `DBG_SCS_BASE + `DBG_SCS_DFSR_OFS,  `DBG_SCS_BASE + `DBG_SCS_DHCSR_OFS,
   `DBG_SCS_BASE + `DBG_SCS_DCRSR_OFS, `DBG_SCS_BASE + `DBG_SCS_DEMCR_OFS,
   `DBG_SCS_BASE + `DBG_SCS_ACTLR_OFS, `DBG_SCS_BASE + `DBG_SCS_CPUID_OFS,
   `DBG_BPU_BASE + `DBG_BPU_CTRL_OFS,  `DBG_BPU_BASE + `DBG_BPU_COMP3_OFS,
   `DBG_BPU_BASE + `DBG_BPU_COMP2_OFS, `DBG_BPU_BASE + `DBG_BPU_COMP1_OFS,
   `DBG_BPU_BASE + `DBG_BPU_COMP0_OFS,
   `DBG_DWT_BASE + `DBG_DWT_CTRL_OFS,  `DBG_DWT_BASE + `DBG_DWT_PCSR_OFS,
   `DBG_DWT_BASE + `DBG_DWT_COMP0_OFS, `DBG_DWT_BASE + `DBG_DWT_MASK0_OFS,
   `DBG_DWT_BASE + `DBG_DWT_FUNC0_OFS, `DBG_DWT_BASE + `DBG_DWT_COMP1_OFS,
   `DBG_DWT_BASE + `DBG_DWT_MASK1_OFS, `DBG_DWT_BASE + `DBG_DWT_FUNC1_OFS
};

// ID blocks in ECO nibble order, SCS then DWT then BPU
localparam logic [31:0] ID_BASE [0:2] = '{`DBG_SCS_BASE, `DBG_DWT_BASE, `DBG_BPU_BASE};
localparam logic [7:0]  ID_PID0 [0:2] = '{
   `DBG_SCS_PID0_VAL, `DBG_DWT_PID0_VAL, `DBG_BPU_PID0_VAL
};
localparam logic [31:0] ID_OFS [0:8] = '{
   `DBG_ID_PID4_OFS, `DBG_ID_PID0_OFS, `DBG_ID_PID1_OFS, `DBG_ID_PID2_OFS, `DBG_ID_PID3_OFS,
   `DBG_ID_CID0_OFS, `DBG_ID_CID1_OFS, `DBG_ID_CID2_OFS, `DBG_ID_CID3_OFS
};
// Fixed bytes per offset, the PID0 and PID3 slots differ per block
localparam logic [7:0]  ID_BYTE [0:8] = '{
   `DBG_PID4_VAL, 8'h00, `DBG_PID1_VAL, `DBG_PID2_VAL, 8'h00,
   `DBG_CID0_VAL, `DBG_CID1_VAL, `DBG_CID2_VAL, `DBG_CID3_VAL
};

// ------------------------------
// Classification rules

// Invasive allows all, non-invasive only reads, always privileged
function automatic logic access_allowed(input logic inv, input logic nid,
                                        input logic wr, input logic priv);
   return (inv || (nid && !wr)) && priv;
endfunction

// Word compare on bits 28 to 2
function automatic logic same_word(input logic [31:0] a, input logic [31:0] b);
   return a[28:2] == b[28:2];
endfunction

// One-hot select vector of a control address
function automatic logic [18:0] ctrl_sels(input logic [31:0] addr);
   logic [18:0] sels;
   int          k;
   sels = '0;
   for (k = 0; k < 19; k++)
      if (same_word(addr, CTRL_ADDR[k]))
         sels[18 - k] = 1'b1;
   return sels;
endfunction

// ID read value; hit marks a listed ID address even when its byte is zero
function automatic logic [31:0] id_value(input logic [31:0] addr, input logic [11:0] eco,
                                         output logic hit);
   logic [7:0] val;
   int         b;
   int         k;
   val = 8'h00;
   hit = 1'b0;
   for (b = 0; b < 3; b++)
      for (k = 0; k < 9; k++)
         if (same_word(addr, ID_BASE[b] + ID_OFS[k]))
         begin
            hit = 1'b1;
            if (k == 1)
               val = ID_PID0[b];
            else if (k == 4)
               val = {eco[11 - 4*b -: 4], 4'h0};
            else
               val = ID_BYTE[k];
         end
   return {24'h000000, val};
endfunction

// Register update at a rising edge, from the inputs seen by that edge
task automatic predict_cycle();
   logic [18:0] sels;
   logic [31:0] id_val;
   logic        id_hit;
   logic        trans;
   logic        ok;
   logic        dec;
   trans  = dif_aphase_i && (dif_addr_i[31:28] == `DBG_PPB_PREFIX);
   ok     = access_allowed(dbg_inv_en_i, niden_i, dif_write_i, dif_priv_i);
   sels   = ctrl_sels(dif_addr_i);
   id_val = id_value(dif_addr_i, eco_rev_i, id_hit);
   dec    = trans && ok && dif_size_bit1_i && ((sels != '0) || id_hit);
   if (!dbg_reset_n)
   begin
      exp_addr   = '0;
      exp_dec    = 1'b0;
      exp_active = 1'b0;
      exp_err    = 1'b0;
      exp_write  = 1'b0;
   end
   else
   begin
      // Strobe drops on every edge unless a new write is accepted
      exp_write = hready_i && dec && dif_write_i;
      if (hready_i)
      begin
         exp_addr   = dif_addr_i;
         exp_dec    = dec;
         exp_active = trans;
         exp_err    = trans && !ok;
      end
   end
endtask

`endif

//--- bench/tb_dbg_ppb_sel.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbg_ppb_params.svh"

module tb_dbg_ppb_sel;

   logic                   dclk = 1'b0;
   logic                   dbg_reset_n;
   logic                   dif_aphase_i;
   dbg_ppb_pkg::ppb_addr_t dif_addr_i;
   logic                   dif_write_i;
   logic                   dif_priv_i;
   logic                   dif_size_bit1_i;
   logic                   hready_i;
   logic                   dbg_inv_en_i;
   logic                   niden_i;
   dbg_ppb_pkg::eco_rev_t  eco_rev_i;
   wire logic [3:0]        dsl_dbg_sels_o;
   wire logic [1:0]        dsl_cid_sels_o;
   wire logic [4:0]        dsl_bpu_sels_o;
   wire logic [7:0]        dsl_dwt_sels_o;
   wire logic              dsl_ppb_write_o;
   wire logic              dsl_ppb_active_o;
   wire logic              dsl_ppb_usr_err_o;
   wire logic [31:0]       dsl_hrdata_o;
   wire logic              dsl_acc_ok_o;

   // Values applied at the next rising edge
   logic        nx_rst_n;
   logic        nx_aphase;
   logic [31:0] nx_addr;
   logic        nx_write;
   logic        nx_priv;
   logic        nx_size;
   logic        nx_hready;
   logic        nx_inv;
   logic        nx_nid;
   logic [11:0] nx_eco;

   // Model state of the registered outputs
   logic [31:0] exp_addr;
   logic        exp_dec;
   logic        exp_active;
   logic        exp_err;
   logic        exp_write;

   integer seed;
   int     test_errs;
   int     total_errs;
   int     tests_run;
   int     tests_failed;

   `include "dbg_ppb_model.svh"

   dbg_ppb_sel i_dut
   (
      .dclk              (dclk),
      .dbg_reset_n       (dbg_reset_n),
      .dif_aphase_i      (dif_aphase_i),
      .dif_addr_i        (dif_addr_i),
      .dif_write_i       (dif_write_i),
      .dif_priv_i        (dif_priv_i),
      .dif_size_bit1_i   (dif_size_bit1_i),
      .hready_i          (hready_i),
      .dbg_inv_en_i      (dbg_inv_en_i),
      .niden_i           (niden_i),
      .eco_rev_i         (eco_rev_i),
      .dsl_dbg_sels_o    (dsl_dbg_sels_o),
      .dsl_cid_sels_o    (dsl_cid_sels_o),
      .dsl_bpu_sels_o    (dsl_bpu_sels_o),
      .dsl_dwt_sels_o    (dsl_dwt_sels_o),
      .dsl_ppb_write_o   (dsl_ppb_write_o),
      .dsl_ppb_active_o  (dsl_ppb_active_o),
      .dsl_ppb_usr_err_o (dsl_ppb_usr_err_o),
      .dsl_hrdata_o      (dsl_hrdata_o),
      .dsl_acc_ok_o      (dsl_acc_ok_o)
   );

   // 100 ns clock
   always #50 dclk = ~dclk;

   // ------------------------------
   // Checking

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
         test_errs++;
      end
   endtask

   // Registered outputs against the model, acc_ok against the live inputs
   task automatic check_outputs();
      logic [18:0] sels;
      logic [31:0] rdata;
      logic        hit;
      sels  = '0;
      rdata = '0;
      if (exp_dec)
      begin
         sels  = ctrl_sels(exp_addr);
         rdata = id_value(exp_addr, eco_rev_i, hit);
      end
      check_value("dsl_dbg_sels_o", 32'(dsl_dbg_sels_o), 32'(sels[18:15]));
      check_value("dsl_cid_sels_o", 32'(dsl_cid_sels_o), 32'(sels[14:13]));
      check_value("dsl_bpu_sels_o", 32'(dsl_bpu_sels_o), 32'(sels[12:8]));
      check_value("dsl_dwt_sels_o", 32'(dsl_dwt_sels_o), 32'(sels[7:0]));
      check_value("dsl_ppb_write_o", 32'(dsl_ppb_write_o), 32'(exp_write));
      check_value("dsl_ppb_active_o", 32'(dsl_ppb_active_o), 32'(exp_active));
      check_value("dsl_ppb_usr_err_o", 32'(dsl_ppb_usr_err_o), 32'(exp_err));
      check_value("dsl_hrdata_o", dsl_hrdata_o, rdata);
      check_value("dsl_acc_ok_o", 32'(dsl_acc_ok_o),
                  32'(access_allowed(dbg_inv_en_i, niden_i, dif_write_i, dif_priv_i)));
   endtask

   // Every select, flag and read-data bit must be a clean zero
   task automatic check_cleared();
      check_value("dsl_dbg_sels_o", 32'(dsl_dbg_sels_o), 32'h0);
      check_value("dsl_cid_sels_o", 32'(dsl_cid_sels_o), 32'h0);
      check_value("dsl_bpu_sels_o", 32'(dsl_bpu_sels_o), 32'h0);
      check_value("dsl_dwt_sels_o", 32'(dsl_dwt_sels_o), 32'h0);
      check_value("dsl_ppb_write_o", 32'(dsl_ppb_write_o), 32'h0);
      check_value("dsl_ppb_active_o", 32'(dsl_ppb_active_o), 32'h0);
      check_value("dsl_ppb_usr_err_o", 32'(dsl_ppb_usr_err_o), 32'h0);
      check_value("dsl_hrdata_o", dsl_hrdata_o, 32'h0);
   endtask

   // ------------------------------
   // Stimulus

   // Model sees the same inputs as the DUT edge, then new values go out
   task automatic cycle();
      @(posedge dclk);
      predict_cycle();
      dbg_reset_n     <= nx_rst_n;
      dif_aphase_i    <= nx_aphase;
      dif_addr_i      <= nx_addr;
      dif_write_i     <= nx_write;
      dif_priv_i      <= nx_priv;
      dif_size_bit1_i <= nx_size;
      hready_i        <= nx_hready;
      dbg_inv_en_i    <= nx_inv;
      niden_i         <= nx_nid;
      eco_rev_i       <= nx_eco;
      // Sample in mid-cycle away from the edge
      @(negedge dclk);
      check_outputs();
   endtask

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   // Kind 0 control, 1 ID, 2 any E000xxxx, 3 outside the PPB
   function automatic logic [31:0] pick_addr(input int kind);
      logic [31:0] r;
      int          idx;
      r = rand_word();
      case (kind)
         0:
         begin
            idx = r % 19;
            return CTRL_ADDR[idx] | 32'(r[30:29]);
         end
         1:
         begin
            idx = r % 27;
            return ID_BASE[idx / 9] + ID_OFS[idx % 9] + 32'(r[30:29]);
         end
         2:
            return {16'hE000, r[15:0]};
         default:
            return {(r[31:28] == 4'hE) ? 4'h2 : r[31:28], r[27:0]};
      endcase
   endfunction

   task automatic set_allowed_read(input logic [31:0] addr);
      nx_aphase = 1'b1;
      nx_addr   = addr;
      nx_write  = 1'b0;
      nx_priv   = 1'b1;
      nx_size   = 1'b1;
      nx_hready = 1'b1;
      nx_inv    = 1'b1;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errs != 0)
         tests_failed++;
      total_errs += test_errs;
      $display("Test %-12s %s, %0d errors", name, (test_errs == 0) ? "ok" : "failing",
               test_errs);
      test_errs = 0;
   endtask

   // ------------------------------
   // Tests

   task automatic run_reset_test();
      int k;
      // Live accesses while reset is held must not show
      for (k = 0; k < 2; k++)
      begin
         set_allowed_read(pick_addr(k));
         cycle();
         check_cleared();
      end
      // Third reset edge releases, then one idle cycle
      nx_rst_n  = 1'b1;
      nx_aphase = 1'b0;
      cycle();
      check_cleared();
      cycle();
      check_cleared();
      finish_test("reset");
   endtask

   task automatic run_id_test();
      logic [31:0] r;
      int          b;
      int          k;
      r      = rand_word();
      nx_eco = r[11:0];
      nx_nid = 1'b1;
      // Back to back reads of every ID register
      for (b = 0; b < 3; b++)
         for (k = 0; k < 9; k++)
         begin
            set_allowed_read(ID_BASE[b] + ID_OFS[k]);
            nx_inv = r[12 + b];
            cycle();
         end
      nx_aphase = 1'b0;
      cycle();
      finish_test("id_reads");
   endtask

   task automatic run_ctrl_test();
      logic [31:0] r;
      int          k;
      int          wait_cnt;
      logic        strobe_seen;
      for (k = 0; k < 19; k++)
      begin
         r = rand_word();
         set_allowed_read(CTRL_ADDR[k]);
         nx_write = r[0];
         cycle();
      end
      // Accepted write held under back-pressure in the next cycle
      set_allowed_read(pick_addr(0));
      nx_write = 1'b1;
      cycle();
      nx_hready   = 1'b0;
      wait_cnt    = 0;
      strobe_seen = 1'b0;
      while (!strobe_seen && wait_cnt < 8)
      begin
         cycle();
         wait_cnt++;
         strobe_seen = dsl_ppb_write_o;
      end
      if (!strobe_seen)
      begin
         $display("Timeout at %0d ns: no write strobe within 8 cycles", $time);
         test_errs++;
      end
      else if (wait_cnt != 1)
      begin
         $display("Write strobe came %0d cycles after the accepting edge", wait_cnt);
         test_errs++;
      end
      // Strobe must drop even with hready low
      cycle();
      check_value("dsl_ppb_write_o", 32'(dsl_ppb_write_o), 32'h0);
      nx_hready = 1'b1;
      nx_aphase = 1'b0;
      cycle();
      finish_test("ctrl_access");
   endtask

   task automatic run_refused_test();
      logic [31:0] r;
      int          k;
      for (k = 0; k < 24; k++)
      begin
         r = rand_word();
         set_allowed_read(pick_addr(int'(r[0])));
         nx_write = r[8];
         case (r[5:4])
            2'd1:
            begin
               nx_inv = 1'b0;
               nx_nid = 1'b0;
            end
            2'd2:
            begin
               // Write with non-invasive debug only
               nx_inv   = 1'b0;
               nx_nid   = 1'b1;
               nx_write = 1'b1;
            end
            default:
            begin
               nx_priv = 1'b0;
               nx_inv  = r[6];
               nx_nid  = r[7];
            end
         endcase
         cycle();
      end
      finish_test("refused");
   endtask

   task automatic run_unmatched_test();
      logic [31:0] r;
      int          k;
      for (k = 0; k < 40; k++)
      begin
         r = rand_word();
         // Listed addresses here only go out as non-word accesses
         set_allowed_read(pick_addr(3 - int'(r[1:0])));
         nx_size   = r[1:0] == 2'd2 || r[1:0] == 2'd3 ? 1'b0 : r[9];
         nx_aphase = r[2] | r[3];
         nx_write  = r[4];
         cycle();
      end
      finish_test("unmatched");
   endtask

   task automatic run_random_test();
      logic [31:0] r;
      int          k;
      for (k = 0; k < 300; k++)
      begin
         r         = rand_word();
         nx_addr   = pick_addr(int'(r[1:0]));
         nx_aphase = r[2] | r[3];
         nx_write  = r[4];
         nx_priv   = r[5] | r[6];
         nx_size   = r[7] | r[8];
         nx_hready = r[9] | r[10];
         nx_inv    = r[11];
         nx_nid    = r[12];
         if (r[15:13] == 3'd0)
            nx_eco = r[27:16];
         cycle();
      end
      nx_aphase = 1'b0;
      nx_hready = 1'b1;
      cycle();
      finish_test("random");
   endtask

   initial
   begin
      seed            = 81;
      test_errs       = 0;
      total_errs      = 0;
      tests_run       = 0;
      tests_failed    = 0;
      dbg_reset_n     = 1'b0;
      dif_aphase_i    = 1'b0;
      dif_addr_i      = '0;
      dif_write_i     = 1'b0;
      dif_priv_i      = 1'b0;
      dif_size_bit1_i = 1'b0;
      hready_i        = 1'b0;
      dbg_inv_en_i    = 1'b0;
      niden_i         = 1'b0;
      eco_rev_i       = '0;
      nx_rst_n        = 1'b0;
      nx_eco          = 12'h000;
      nx_nid          = 1'b0;
      exp_addr        = '0;
      exp_dec         = 1'b0;
      exp_active      = 1'b0;
      exp_err         = 1'b0;
      exp_write       = 1'b0;
      run_reset_test();
      run_id_test();
      run_ctrl_test();
      run_refused_test();
      run_unmatched_test();
      run_random_test();
      $display("Summary: %0d tests, %0d failing, %0d errors", tests_run, tests_failed,
               total_errs);
      if (total_errs == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/dbg_id_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbg_ppb_params.svh"

module dbg_id_rom
#(
   parameter int BPU_PRESENT = 1,
   parameter int DWT_PRESENT = 1
)
(
   input  wire dbg_ppb_pkg::ppb_hash_t sel_hash_i,
   input  wire dbg_ppb_pkg::eco_rev_t  eco_rev_i,
   output dbg_ppb_pkg::ppb_data_t      id_rdata_o
);

   dbg_ppb_pkg::ppb_data_t scs_ids;
   dbg_ppb_pkg::ppb_data_t dwt_ids;
   dbg_ppb_pkg::ppb_data_t bpu_ids;

   // ------------------------------
   // ID set of one block
   // Codes are unique, so at most one term is live and the OR is a mux
   function automatic dbg_ppb_pkg::ppb_data_t block_ids
   (
      input dbg_ppb_pkg::ppb_hash_t h,
      input dbg_ppb_pkg::ppb_addr_t base,
      input logic [7:0]             pid0,
      input logic [3:0]             eco
   );
      logic [7:0] id_byte;
      logic [7:0] pid3;
      // Revision nibble sits in the upper half of PID3
      pid3    = {eco, 4'h0};
      id_byte = 8'h00;
      id_byte |= {8{h == dbg_ppb_pkg::ppb_hash(base + `DBG_ID_PID4_OFS)}} & `DBG_PID4_VAL;
      id_byte |= {8{h == dbg_ppb_pkg::ppb_hash(base + `DBG_ID_PID0_OFS)}} & pid0;
      id_byte |= {8{h == dbg_ppb_pkg::ppb_hash(base + `DBG_ID_PID1_OFS)}} & `DBG_PID1_VAL;
      id_byte |= {8{h == dbg_ppb_pkg::ppb_hash(base + `DBG_ID_PID2_OFS)}} & `DBG_PID2_VAL;
      id_byte |= {8{h == dbg_ppb_pkg::ppb_hash(base + `DBG_ID_PID3_OFS)}} & pid3;
      // Component ID preamble
      id_byte |= {8{h == dbg_ppb_pkg::ppb_hash(base + `DBG_ID_CID0_OFS)}} & `DBG_CID0_VAL;
      id_byte |= {8{h == dbg_ppb_pkg::ppb_hash(base + `DBG_ID_CID1_OFS)}} & `DBG_CID1_VAL;
      id_byte |= {8{h == dbg_ppb_pkg::ppb_hash(base + `DBG_ID_CID2_OFS)}} & `DBG_CID2_VAL;
      id_byte |= {8{h == dbg_ppb_pkg::ppb_hash(base + `DBG_ID_CID3_OFS)}} & `DBG_CID3_VAL;
      return {24'h000000, id_byte};
   endfunction

   // ------------------------------
   // Per-block ID words

   // SCS takes the top ECO nibble
   assign scs_ids = block_ids(sel_hash_i, `DBG_SCS_BASE, `DBG_SCS_PID0_VAL,
                              eco_rev_i[11:8]);

   // Absent units read as zero
   assign dwt_ids = (DWT_PRESENT != 0) ?
                    block_ids(sel_hash_i, `DBG_DWT_BASE, `DBG_DWT_PID0_VAL,
                              eco_rev_i[7:4]) : '0;

   assign bpu_ids = (BPU_PRESENT != 0) ?
                    block_ids(sel_hash_i, `DBG_BPU_BASE, `DBG_BPU_PID0_VAL,
                              eco_rev_i[3:0]) : '0;

   // Idle, error and null codes match nothing and give zero
   assign id_rdata_o = scs_ids | dwt_ids | bpu_ids;

endmodule

`default_nettype wire

//--- logic/dbg_ppb_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbg_ppb_params.svh"

module dbg_ppb_addr_decode
(
   input  wire logic                   dclk,
   input  wire logic                   dbg_reset_n,
   input  wire logic                   dif_aphase_i,
   input  wire logic                   dif_write_i,
   input  wire logic                   dif_priv_i,
   input  wire logic                   dif_size_bit1_i,
   input  wire logic                   hready_i,
   input  wire logic                   dbg_inv_en_i,
   input  wire logic                   niden_i,
   input  wire dbg_ppb_pkg::ppb_addr_t dif_addr_i,
   output dbg_ppb_pkg::ppb_hash_t      sel_hash_o,
   output logic                        ppb_write_o,
   output logic                        acc_ok_o,
   output logic                        ppb_active_o,
   output logic                        usr_err_o
);

   // ------------------------------
   // Decoded address lists

   // Control registers of all three blocks
   localparam dbg_ppb_pkg::ppb_addr_t CTRL_LIST [0:18] = '{
      `DBG_DWT_BASE + `DBG_DWT_CTRL_OFS,  `DBG_DWT_BASE + `DBG_DWT_PCSR_OFS,
      `DBG_DWT_BASE + `DBG_DWT_COMP0_OFS, `DBG_DWT_BASE + `DBG_DWT_MASK0_OFS,
      `DBG_DWT_BASE + `DBG_DWT_FUNC0_OFS, `DBG_DWT_BASE + `DBG_DWT_COMP1_OFS,
      `DBG_DWT_BASE + `DBG_DWT_MASK1_OFS, `DBG_DWT_BASE + `DBG_DWT_FUNC1_OFS,
      `DBG_BPU_BASE + `DBG_BPU_CTRL_OFS,  `DBG_BPU_BASE + `DBG_BPU_COMP0_OFS,
      `DBG_BPU_BASE + `DBG_BPU_COMP1_OFS, `DBG_BPU_BASE + `DBG_BPU_COMP2_OFS,
      `DBG_BPU_BASE + `DBG_BPU_COMP3_OFS,
      `DBG_SCS_BASE + `DBG_SCS_ACTLR_OFS, `DBG_SCS_BASE + `DBG_SCS_CPUID_OFS,
      `DBG_SCS_BASE + `DBG_SCS_DFSR_OFS,  `DBG_SCS_BASE + `DBG_SCS_DHCSR_OFS,
      `DBG_SCS_BASE + `DBG_SCS_DCRSR_OFS, `DBG_SCS_BASE + `DBG_SCS_DEMCR_OFS
   };

   // Blocks carrying an ID register set
   localparam dbg_ppb_pkg::ppb_addr_t ID_BASES [0:2] = '{
      `DBG_SCS_BASE, `DBG_DWT_BASE, `DBG_BPU_BASE
   };

   // ID offsets, same layout in every block
   localparam dbg_ppb_pkg::ppb_addr_t ID_OFS [0:8] = '{
      `DBG_ID_PID4_OFS, `DBG_ID_PID0_OFS, `DBG_ID_PID1_OFS,
      `DBG_ID_PID2_OFS, `DBG_ID_PID3_OFS, `DBG_ID_CID0_OFS,
      `DBG_ID_CID1_OFS, `DBG_ID_CID2_OFS, `DBG_ID_CID3_OFS
   };

   logic                   ppb_trans;
   logic                   acc_ok;
   logic                   addr_hit;
   logic                   dec_valid;
   logic                   ppb_write_nxt;
   dbg_ppb_pkg::ppb_hash_t hash_nxt;
   dbg_ppb_pkg::ppb_hash_t sel_hash_q;
   logic                   ppb_write_q;

   // Debug slot aimed at the PPB region
   assign ppb_trans = dif_aphase_i & (dif_addr_i[31:28] == `DBG_PPB_PREFIX);

   // Invasive debug allows all, non-invasive only reads
   // Privilege is required in both cases
   assign acc_ok = (dbg_inv_en_i | (niden_i & ~dif_write_i)) & dif_priv_i;

   // Word compare on bits 28 to 2
   always_comb
   begin : match_blk
      dbg_ppb_pkg::ppb_addr_t cand;
      int                     i;
      int                     j;
      cand     = '0;
      addr_hit = 1'b0;
      for (i = 0; i < 19; i++)
      begin
         cand = CTRL_LIST[i];
         addr_hit |= (dif_addr_i[28:2] == cand[28:2]);
      end
      // Expand base and offset for each ID register
      for (i = 0; i < 3; i++)
      begin
         for (j = 0; j < 9; j++)
         begin
            cand = ID_BASES[i] + ID_OFS[j];
            addr_hit |= (dif_addr_i[28:2] == cand[28:2]);
         end
      end
   end

   // Decoded hits must also be word accesses
   assign dec_valid = addr_hit & dif_size_bit1_i;

   // ------------------------------
   // Classification into next hash
   always_comb
   begin
      if (!ppb_trans)
         hash_nxt = '0;
      else if (!acc_ok)
         hash_nxt = `DBG_HASH_ERR;
      else if (dec_valid)
         hash_nxt = dbg_ppb_pkg::ppb_hash(dif_addr_i);
      else
         hash_nxt = `DBG_HASH_NULL;
   end

   // Strobe only for an accepted, allowed and decoded write
   assign ppb_write_nxt = hready_i & ppb_trans & acc_ok & dec_valid & dif_write_i;

   // Select holds through back-pressure
   always_ff @(posedge dclk or negedge dbg_reset_n)
   begin
      if (!dbg_reset_n)
         sel_hash_q <= '0;
      else if (hready_i)
         sel_hash_q <= hash_nxt;
   end

   // Write strobe self-clears every cycle, hready or not
   always_ff @(posedge dclk or negedge dbg_reset_n)
   begin
      if (!dbg_reset_n)
         ppb_write_q <= 1'b0;
      else
         ppb_write_q <= ppb_write_nxt;
   end

   assign sel_hash_o   = sel_hash_q;
   assign ppb_write_o  = ppb_write_q;
   assign acc_ok_o     = acc_ok;
   // PPB owns the data phase whenever a code is loaded
   assign ppb_active_o = (sel_hash_q != '0);
   assign usr_err_o    = (sel_hash_q == `DBG_HASH_ERR);

endmodule

`default_nettype wire

//--- logic/dbg_ppb_params.svh
`ifndef DBG_PPB_PARAMS_SVH
`define DBG_PPB_PARAMS_SVH

// PPB region prefix, address bits 31 to 28
`define DBG_PPB_PREFIX      4'hE

// ------------------------------
// Block base addresses
`define DBG_DWT_BASE        32'hE0001000
`define DBG_BPU_BASE        32'hE0002000
`define DBG_SCS_BASE        32'hE000E000

// DWT control registers, offsets from DWT base
`define DBG_DWT_CTRL_OFS    32'h000
`define DBG_DWT_PCSR_OFS    32'h01C
`define DBG_DWT_COMP0_OFS   32'h020
`define DBG_DWT_MASK0_OFS   32'h024
`define DBG_DWT_FUNC0_OFS   32'h028
`define DBG_DWT_COMP1_OFS   32'h030
`define DBG_DWT_MASK1_OFS   32'h034
`define DBG_DWT_FUNC1_OFS   32'h038

// BPU control and comparator registers
`define DBG_BPU_CTRL_OFS    32'h000
`define DBG_BPU_COMP0_OFS   32'h008
`define DBG_BPU_COMP1_OFS   32'h00C
`define DBG_BPU_COMP2_OFS   32'h010
`define DBG_BPU_COMP3_OFS   32'h014

// SCS debug and core-ID registers
`define DBG_SCS_ACTLR_OFS   32'h008
`define DBG_SCS_CPUID_OFS   32'hD00
`define DBG_SCS_DFSR_OFS    32'hD30
`define DBG_SCS_DHCSR_OFS   32'hDF0
`define DBG_SCS_DCRSR_OFS   32'hDF4
`define DBG_SCS_DEMCR_OFS   32'hDFC

// ------------------------------
// ID register offsets, common to all blocks
`define DBG_ID_PID4_OFS     32'hFD0
`define DBG_ID_PID0_OFS     32'hFE0
`define DBG_ID_PID1_OFS     32'hFE4
`define DBG_ID_PID2_OFS     32'hFE8
`define DBG_ID_PID3_OFS     32'hFEC
`define DBG_ID_CID0_OFS     32'hFF0
`define DBG_ID_CID1_OFS     32'hFF4
`define DBG_ID_CID2_OFS     32'hFF8
`define DBG_ID_CID3_OFS     32'hFFC

// ID byte values, PID3 is built from the ECO nibble
`define DBG_PID4_VAL        8'h04
`define DBG_SCS_PID0_VAL    8'h08
`define DBG_DWT_PID0_VAL    8'h0A
`define DBG_BPU_PID0_VAL    8'h0B
`define DBG_PID1_VAL        8'hB0
`define DBG_PID2_VAL        8'h0B
`define DBG_CID0_VAL        8'h0D
`define DBG_CID1_VAL        8'hE0
`define DBG_CID2_VAL        8'h05
`define DBG_CID3_VAL        8'hB1

// Reserved hash codes
`define DBG_HASH_NULL       7'h7F
`define DBG_HASH_ERR        7'h01

`endif

//--- logic/dbg_ppb_pkg.sv
`default_nettype none

package dbg_ppb_pkg;

   // Debug transaction address
   typedef logic [31:0] ppb_addr_t;

   // Read-data word returned on the debug bus
   typedef logic [31:0] ppb_data_t;

   // Compressed register select
   // Zero is idle, all ones an unmatched PPB hit, one a refused access
   typedef logic [6:0]  ppb_hash_t;

   // ECO revision nibbles, SCS in 11:8, DWT in 7:4, BPU in 3:0
   typedef logic [11:0] eco_rev_t;

   // Address compression
   // Gives a unique nonzero code for every decoded PPB register
   function automatic ppb_hash_t ppb_hash(input ppb_addr_t addr);
      return {addr[2] ^ addr[5],
              addr[2] ^ addr[13],
              addr[3] ^ addr[4],
              addr[3] ^ addr[12],
              addr[6] ^ addr[15],
              addr[9],
              addr[12]};
   endfunction

endpackage

`default_nettype wire

//--- logic/dbg_ppb_sel.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_ppb_sel
#(
   parameter int BPU_PRESENT = 1,
   parameter int DWT_PRESENT = 1
)
(
   input  wire logic                   dclk,
   input  wire logic                   dbg_reset_n,
   // Address phase of the debug transaction
   input  wire logic                   dif_aphase_i,
   input  wire dbg_ppb_pkg::ppb_addr_t dif_addr_i,
   input  wire logic                   dif_write_i,
   input  wire logic                   dif_priv_i,
   input  wire logic                   dif_size_bit1_i,
   input  wire logic                   hready_i,
   // Static debug enables and revision
   input  wire logic                   dbg_inv_en_i,
   input  wire logic                   niden_i,
   input  wire dbg_ppb_pkg::eco_rev_t  eco_rev_i,
   // Data-phase results
   output logic [3:0]                  dsl_dbg_sels_o,
   output logic [1:0]                  dsl_cid_sels_o,
   output logic [4:0]                  dsl_bpu_sels_o,
   output logic [7:0]                  dsl_dwt_sels_o,
   output logic                        dsl_ppb_write_o,
   output logic                        dsl_ppb_active_o,
   output logic                        dsl_ppb_usr_err_o,
   output dbg_ppb_pkg::ppb_data_t      dsl_hrdata_o,
   output logic                        dsl_acc_ok_o
);

   // Registered select code shared by both data-phase parts
   dbg_ppb_pkg::ppb_hash_t sel_hash;

   // Address phase, one cycle ahead of everything else
   dbg_ppb_addr_decode i_addr_decode
   (
      .dclk            (dclk),
      .dbg_reset_n     (dbg_reset_n),
      .dif_aphase_i    (dif_aphase_i),
      .dif_write_i     (dif_write_i),
      .dif_priv_i      (dif_priv_i),
      .dif_size_bit1_i (dif_size_bit1_i),
      .hready_i        (hready_i),
      .dbg_inv_en_i    (dbg_inv_en_i),
      .niden_i         (niden_i),
      .dif_addr_i      (dif_addr_i),
      .sel_hash_o      (sel_hash),
      .ppb_write_o     (dsl_ppb_write_o),
      .acc_ok_o        (dsl_acc_ok_o),
      .ppb_active_o    (dsl_ppb_active_o),
      .usr_err_o       (dsl_ppb_usr_err_o)
   );

   // Register selects for the control blocks
   dbg_reg_select #(.BPU_PRESENT(BPU_PRESENT), .DWT_PRESENT(DWT_PRESENT)) i_reg_select
   (
      .sel_hash_i (sel_hash),
      .dbg_sels_o (dsl_dbg_sels_o),
      .cid_sels_o (dsl_cid_sels_o),
      .bpu_sels_o (dsl_bpu_sels_o),
      .dwt_sels_o (dsl_dwt_sels_o)
   );

   // Hard-wired component IDs, side by side with the selects
   dbg_id_rom #(.BPU_PRESENT(BPU_PRESENT), .DWT_PRESENT(DWT_PRESENT)) i_id_rom
   (
      .sel_hash_i (sel_hash),
      .eco_rev_i  (eco_rev_i),
      .id_rdata_o (dsl_hrdata_o)
   );

endmodule

`default_nettype wire

//--- logic/dbg_reg_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "dbg_ppb_params.svh"

module dbg_reg_select
#(
   parameter int BPU_PRESENT = 1,
   parameter int DWT_PRESENT = 1
)
(
   input  wire dbg_ppb_pkg::ppb_hash_t sel_hash_i,
   output logic [3:0]                  dbg_sels_o,
   output logic [1:0]                  cid_sels_o,
   output logic [4:0]                  bpu_sels_o,
   output logic [7:0]                  dwt_sels_o
);

   logic [4:0] bpu_sels;
   logic [7:0] dwt_sels;

   // ------------------------------
   // Debug control block
   // Each bit is a compare of the held code against one register hash

   // DFSR, DHCSR, DCRSR, DEMCR
   assign dbg_sels_o = {
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_SCS_BASE + `DBG_SCS_DFSR_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_SCS_BASE + `DBG_SCS_DHCSR_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_SCS_BASE + `DBG_SCS_DCRSR_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_SCS_BASE + `DBG_SCS_DEMCR_OFS)
   };

   // Core-ID pair, ACTLR then CPUID
   assign cid_sels_o = {
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_SCS_BASE + `DBG_SCS_ACTLR_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_SCS_BASE + `DBG_SCS_CPUID_OFS)
   };

   // ------------------------------
   // Breakpoint unit

   // CTRL, then comparators from 3 down to 0
   assign bpu_sels = {
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_BPU_BASE + `DBG_BPU_CTRL_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_BPU_BASE + `DBG_BPU_COMP3_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_BPU_BASE + `DBG_BPU_COMP2_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_BPU_BASE + `DBG_BPU_COMP1_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_BPU_BASE + `DBG_BPU_COMP0_OFS)
   };

   // ------------------------------
   // Watchpoint unit

   // CTRL, PCSR, then comparator 0 and 1 triplets
   assign dwt_sels = {
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_DWT_BASE + `DBG_DWT_CTRL_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_DWT_BASE + `DBG_DWT_PCSR_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_DWT_BASE + `DBG_DWT_COMP0_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_DWT_BASE + `DBG_DWT_MASK0_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_DWT_BASE + `DBG_DWT_FUNC0_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_DWT_BASE + `DBG_DWT_COMP1_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_DWT_BASE + `DBG_DWT_MASK1_OFS),
      sel_hash_i == dbg_ppb_pkg::ppb_hash(`DBG_DWT_BASE + `DBG_DWT_FUNC1_OFS)
   };

   // Absent units never see a select
   assign bpu_sels_o = (BPU_PRESENT != 0) ? bpu_sels : '0;
   assign dwt_sels_o = (DWT_PRESENT != 0) ? dwt_sels : '0;

endmodule

`default_nettype wire

//--- sim.f
+incdir+logic
+incdir+bench
logic/dbg_ppb_pkg.sv
logic/dbg_ppb_addr_decode.sv
logic/dbg_reg_select.sv
logic/dbg_id_rom.sv
logic/dbg_ppb_sel.sv
bench/tb_dbg_ppb_sel.sv
